//--- audio_config.svh
// Audio transmitter configuration
// Sample and slot widths, bit-clock divider and FIFO size

`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

//----------------------------------------------------------------------
// Sample format
//----------------------------------------------------------------------

// Bits per channel sample
`define SAMPLE_WIDTH 16

// Bits per channel slot on the serial line, not below SAMPLE_WIDTH
`define SLOT_WIDTH 32

//----------------------------------------------------------------------
// Clocking and buffering
//----------------------------------------------------------------------

// audioClk cycles per bclk half period
`define BCLK_HALF 4

// Stereo frames held in the sample FIFO
`define FIFO_DEPTH 4

`endif

//--- audioSamplePkg.sv
// Audio sample types
// Channel samples, packed stereo frames and line slots

package audioSamplePkg;

    `include "audio_config.svh"

    // One channel sample as written by the host
    typedef logic [`SAMPLE_WIDTH-1:0] sampleT;

    // Stereo frame
    // Left sample in the upper half, right in the lower half
    typedef logic [2*`SAMPLE_WIDTH-1:0] stereoFrameT;

    // One channel slot as it goes out on sdata
    // Sample at the top, zero padding below
    typedef logic [`SLOT_WIDTH-1:0] slotT;

endpackage

//--- i2sTimingPkg.sv
// I2S timing types
// Divider and bit counters plus the serializer state encoding

package i2sTimingPkg;

    `include "audio_config.svh"

    // Divider width, kept at one bit for a divide-by-one setup
    localparam int DivWidth = (`BCLK_HALF > 1) ? $clog2(`BCLK_HALF) : 1;

    // audioClk cycles within one bclk half period
    typedef logic [DivWidth-1:0] divCountT;

    // Bit position within a stereo frame, 0 to 2*SLOT_WIDTH-1
    typedef logic [$clog2(2*`SLOT_WIDTH)-1:0] bitIndexT;

    // Serializer FSM
    typedef enum logic
    {
        idle,
        streaming
    } serStateT;

endpackage

//--- sampleFifo.sv
// Stereo sample FIFO
// Circular buffer of stereo frames between the host writes and the
// serializer; writes while full are dropped

`timescale 1ns/10ps

`include "audio_config.svh"

module sampleFifo (
    input  logic                        audioClk,
    input  logic                        reset,
    input  logic                        write,
    input  audioSamplePkg::stereoFrameT writeData,
    input  logic                        pop,
    output audioSamplePkg::stereoFrameT headFrame,
    output logic                        full,
    output logic                        empty
);

    import audioSamplePkg::*;

    localparam int PtrWidth = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
    localparam int CountWidth = $clog2(`FIFO_DEPTH + 1);

    // Frame storage
    stereoFrameT mem [`FIFO_DEPTH];

    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  wrEn;
    logic                  popEn;

    //----------------------------------------------------------------------
    // Qualified strobes
    //----------------------------------------------------------------------

    // Writes while full are dropped
    assign wrEn = write && !full;
    // Guard against a stray pop on an empty buffer
    assign popEn = pop && !empty;

    //----------------------------------------------------------------------
    // Storage and pointers
    //----------------------------------------------------------------------

    always_ff @(posedge audioClk)
    begin
        if (wrEn)
        begin
            mem[wrPtr] <= writeData;
        end
    end

    always_ff @(posedge audioClk)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
        end
        else
        begin
            // Wrap at the last entry, depth need not be a power of two
            if (wrEn)
            begin
                wrPtr <= (wrPtr == PtrWidth'(`FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popEn)
            begin
                rdPtr <= (rdPtr == PtrWidth'(`FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
        end
    end

    //----------------------------------------------------------------------
    // Occupancy and flags
    //----------------------------------------------------------------------

    always_ff @(posedge audioClk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else
        begin
            case ({wrEn, popEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Flags follow the count, so full rises the cycle after the last write
    assign full = (count == CountWidth'(`FIFO_DEPTH));
    assign empty = (count == '0);

    // Oldest frame, valid whenever empty is low
    assign headFrame = mem[rdPtr];

    // Serializer must only pop a frame that is there
    assert property (@(posedge audioClk) disable iff (reset) pop |-> !empty);

    // Pointers only meet when the buffer is empty or full
    assert property (@(posedge audioClk) disable iff (reset)
        (wrPtr == rdPtr) == (empty || full));

endmodule

//--- i2sClockGen.sv
// I2S clock generator
// Divides audioClk down to bclk and lrclk and marks each bclk fall
// and the fall that opens a new stereo frame

`timescale 1ns/10ps

`include "audio_config.svh"

module i2sClockGen (
    input  logic audioClk,
    input  logic reset,
    output logic bclk,
    output logic lrclk,
    output logic bclkFall,
    output logic frameStart
);

    import i2sTimingPkg::*;

    divCountT divCount;
    bitIndexT bitIndex;
    logic     halfTick;

    //----------------------------------------------------------------------
    // Bit clock divider
    //----------------------------------------------------------------------

    // Last audioClk cycle of a bclk half period
    assign halfTick = (divCount == divCountT'(`BCLK_HALF - 1));

    always_ff @(posedge audioClk)
    begin
        if (reset)
            divCount <= '0;
        else if (halfTick)
            divCount <= '0;
        else
            divCount <= divCount + 1'b1;
    end

    always_ff @(posedge audioClk)
    begin
        if (reset)
            bclk <= 1'b0;
        else if (halfTick)
            bclk <= ~bclk;
    end

    // bclk high and about to toggle, so it falls at this edge
    assign bclkFall = halfTick && bclk;

    //----------------------------------------------------------------------
    // Word select
    // Low for the left slot, high for the right slot
    //----------------------------------------------------------------------

    // Counts bit clocks, one step per fall
    always_ff @(posedge audioClk)
    begin
        if (reset)
            bitIndex <= '0;
        else if (bclkFall)
            bitIndex <= (bitIndex == bitIndexT'(2*`SLOT_WIDTH - 1)) ? '0 : bitIndex + 1'b1;
    end

    // Changes every SLOT_WIDTH falls
    // First fall after reset keeps it low
    always_ff @(posedge audioClk)
    begin
        if (reset)
            lrclk <= 1'b0;
        else if (bclkFall && bitIndex == '0)
            lrclk <= 1'b0;
        else if (bclkFall && bitIndex == bitIndexT'(`SLOT_WIDTH))
            lrclk <= 1'b1;
    end

    // Fall that starts the left slot
    assign frameStart = bclkFall && (bitIndex == '0);

    // Fall ends a high phase of at most BCLK_HALF cycles
    assert property (@(posedge audioClk) disable iff (reset)
        bclkFall |-> bclk && !$past(bclk, `BCLK_HALF));

    // Every frame start but the first closes a right slot
    assert property (@(posedge audioClk) disable iff (reset)
        frameStart |-> lrclk || $past(reset, 2*`BCLK_HALF));

endmodule

//--- i2sSerializer.sv
// I2S serializer
// Loads one stereo frame per frame start and shifts it out MSB first
// with the one-bit I2S delay; zero frame and underrun pulse when empty

`timescale 1ns/10ps

`include "audio_config.svh"

module i2sSerializer (
    input  logic                        audioClk,
    input  logic                        reset,
    input  logic                        bclkFall,
    input  logic                        frameStart,
    input  audioSamplePkg::stereoFrameT headFrame,
    input  logic                        fifoEmpty,
    output logic                        fifoPop,
    output logic                        sdata,
    output logic                        underrun
);

    import audioSamplePkg::*;
    import i2sTimingPkg::*;

    localparam int FrameBits = 2 * `SLOT_WIDTH;

    serStateT             state;
    logic [FrameBits-1:0] shiftReg;
    logic [FrameBits-1:0] nextFrame;
    sampleT               leftSample;
    sampleT               rightSample;

    // Sample at the top of the slot, zeros below
    function automatic slotT padSlot(input sampleT sample);
        slotT slot;
        slot = '0;
        slot[`SLOT_WIDTH-1 -: `SAMPLE_WIDTH] = sample;
        return slot;
    endfunction

    //----------------------------------------------------------------------
    // Frame fetch
    //----------------------------------------------------------------------

    // Left channel in the upper half of the frame
    assign leftSample = headFrame[2*`SAMPLE_WIDTH-1 -: `SAMPLE_WIDTH];
    assign rightSample = headFrame[`SAMPLE_WIDTH-1:0];

    // Silent frame when nothing is waiting
    assign nextFrame = fifoEmpty ? '0 : {padSlot(leftSample), padSlot(rightSample)};

    // Pop and underrun share the frame start cycle
    assign fifoPop = frameStart && !fifoEmpty;
    assign underrun = frameStart && fifoEmpty;

    //----------------------------------------------------------------------
    // Serializer FSM
    //----------------------------------------------------------------------

    always_ff @(posedge audioClk)
    begin
        if (reset)
        begin
            state <= idle;
        end
        else
        begin
            case (state)
                idle:
                begin
                    // First frame start begins the stream
                    if (frameStart)
                        state <= streaming;
                end
                streaming: state <= streaming;
                default:   state <= idle;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Shift path
    //----------------------------------------------------------------------

    // Reload on frame start, shift left on every other fall
    always_ff @(posedge audioClk)
    begin
        if (frameStart)
            shiftReg <= nextFrame;
        else if (bclkFall)
            shiftReg <= {shiftReg[FrameBits-2:0], 1'b0};
    end

    // One fall behind the shift register, giving the I2S delay bit
    // On frame start this sends the last right bit of the old frame
    always_ff @(posedge audioClk)
    begin
        if (reset)
            sdata <= 1'b0;
        else if (bclkFall)
            sdata <= (state == streaming) ? shiftReg[FrameBits-1] : 1'b0;
    end

    // Only the last right bit is left when the next frame loads
    assert property (@(posedge audioClk) disable iff (reset)
        (frameStart && state == streaming) |-> (shiftReg[FrameBits-2:0] == '0));

endmodule

//--- i2sTransmitter.sv
// I2S transmitter top level
// Sample FIFO feeding a serializer paced by the I2S clock generator

`timescale 1ns/10ps

module i2sTransmitter (
    input  logic                        audioClk,
    input  logic                        reset,
    input  logic                        sampleWrite,
    input  audioSamplePkg::stereoFrameT sampleData,
    output logic                        fifoFull,
    output logic                        bclk,
    output logic                        lrclk,
    output logic                        sdata,
    output logic                        underrun
);

    import audioSamplePkg::*;

    // FIFO to serializer
    stereoFrameT headFrame;
    logic        fifoEmpty;
    logic        fifoPop;

    // Clock generator strobes
    logic        bclkFall;
    logic        frameStart;

    sampleFifo fifo (
        .audioClk  (audioClk),
        .reset     (reset),
        .write     (sampleWrite),
        .writeData (sampleData),
        .pop       (fifoPop),
        .headFrame (headFrame),
        .full      (fifoFull),
        .empty     (fifoEmpty)
    );

    i2sClockGen clockGen (
        .audioClk   (audioClk),
        .reset      (reset),
        .bclk       (bclk),
        .lrclk      (lrclk),
        .bclkFall   (bclkFall),
        .frameStart (frameStart)
    );

    i2sSerializer serializer (
        .audioClk   (audioClk),
        .reset      (reset),
        .bclkFall   (bclkFall),
        .frameStart (frameStart),
        .headFrame  (headFrame),
        .fifoEmpty  (fifoEmpty),
        .fifoPop    (fifoPop),
        .sdata      (sdata),
        .underrun   (underrun)
    );

endmodule

//--- tb_i2sTransmitter.sv
// I2S transmitter testbench
// Writes a table of stereo frames and decodes the serial line, checking
// sample order, slot format, clock ratios, FIFO full and underrun

`timescale 1ns/10ps

`include "audio_config.svh"

module tb_i2sTransmitter;

    import audioSamplePkg::*;

    localparam int ClkPeriod = 40;
    localparam int StreamRows = 10;
    localparam int BurstRows = `FIFO_DEPTH + 2;
    localparam int TableRows = StreamRows + BurstRows;
    localparam int FrameCycles = 2 * `SLOT_WIDTH * 2 * `BCLK_HALF;
    localparam longint TimeoutNs = longint'(TableRows + 4) * FrameCycles * ClkPeriod;
    localparam int PadBits = `SLOT_WIDTH - `SAMPLE_WIDTH;

    logic        audioClk;
    logic        reset;
    logic        sampleWrite;
    stereoFrameT sampleData;
    logic        fifoFull;
    logic        bclk;
    logic        lrclk;
    logic        sdata;
    logic        underrun;

    // Stimulus table: frame, burst row, expected to be accepted
    stereoFrameT frameTab [TableRows];
    bit          burstTab [TableRows];
    bit          acceptTab [TableRows];

    // Accepted frames still to appear on the line
    stereoFrameT expected [$];

    int checkCount = 0;
    int errorCount = 0;
    int zeroFrames = 0;
    int pendingUnderruns = 0;

    // Monitor state
    logic prevBclk;
    logic prevLr;
    logic underrunLast;
    int   halfCount;
    int   bclkToggles;
    int   bitCount;
    int   lrEdges;
    slotT shiftWord;
    slotT leftSlot;

    i2sTransmitter dut (
        .audioClk    (audioClk),
        .reset       (reset),
        .sampleWrite (sampleWrite),
        .sampleData  (sampleData),
        .fifoFull    (fifoFull),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .sdata       (sdata),
        .underrun    (underrun)
    );

    initial
    begin
        audioClk = 1'b0;
        forever #(ClkPeriod / 2) audioClk = ~audioClk;
    end

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------

    task automatic checkThat(input bit cond, input string msg);
        checkCount++;
        assert (cond)
        else
        begin
            errorCount++;
            $display("error at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic checkResetLevels(input string when);
        checkThat(!bclk && !lrclk && !sdata && !underrun && !fifoFull,
            $sformatf("outputs not low %s: bclk %b lrclk %b sdata %b underrun %b full %b",
                when, bclk, lrclk, sdata, underrun, fifoFull));
    endtask

    // One write strobe, driven on the falling edge
    task automatic writeFrame(input stereoFrameT frame);
        sampleWrite = 1'b1;
        sampleData = frame;
        @(negedge audioClk);
        sampleWrite = 1'b0;
    endtask

    task automatic fillTable();
        stereoFrameT value;
        sampleT      msbOnly;
        sampleT      ones;
        sampleT      alt;
        int          row;
        msbOnly = '0;
        msbOnly[`SAMPLE_WIDTH-1] = 1'b1;
        ones = '1;
        alt = {(`SAMPLE_WIDTH / 2){2'b10}};
        // Corner values first
        frameTab[0] = {msbOnly, ~msbOnly};
        frameTab[1] = {ones, sampleT'(1)};
        frameTab[2] = {sampleT'(0), ones};
        frameTab[3] = {alt, ~alt};
        for (row = 4; row < TableRows; row++)
        begin
            value = stereoFrameT'({$urandom, $urandom});
            // All-zero frame would look like an underrun
            if (value == '0)
                value = stereoFrameT'(1);
            frameTab[row] = value;
        end
        for (row = 0; row < TableRows; row++)
        begin
            burstTab[row] = (row >= StreamRows);
            // Burst into an empty FIFO keeps only FIFO_DEPTH frames
            acceptTab[row] = (row < StreamRows) || (row - StreamRows < `FIFO_DEPTH);
        end
    endtask

    // Frame pulled off the line, compared with the next accepted frame
    task automatic checkDecodedFrame(input slotT lSlot, input slotT rSlot);
        stereoFrameT want;
        slotT        wantLeft;
        slotT        wantRight;
        if (lSlot == '0 && rSlot == '0)
        begin
            checkThat(pendingUnderruns > 0, "zero frame on the line without underrun pulse");
            if (pendingUnderruns > 0)
                pendingUnderruns--;
            zeroFrames++;
        end
        else if (expected.size() == 0)
        begin
            checkThat(1'b0, $sformatf("unexpected frame %h %h on the line", lSlot, rSlot));
        end
        else
        begin
            want = expected.pop_front();
            // Sample in the top bits, zeros below
            wantLeft = slotT'(want[2*`SAMPLE_WIDTH-1 -: `SAMPLE_WIDTH]) << PadBits;
            wantRight = slotT'(want[`SAMPLE_WIDTH-1:0]) << PadBits;
            checkThat(lSlot == wantLeft,
                $sformatf("left slot %h, expected %h", lSlot, wantLeft));
            checkThat(rSlot == wantRight,
                $sformatf("right slot %h, expected %h", rSlot, wantRight));
        end
    endtask

    // Bit sampled on a bclk rise
    // On an lrclk change it is the last bit of the previous channel
    task automatic decodeBit();
        shiftWord = {shiftWord[`SLOT_WIDTH-2:0], sdata};
        bitCount++;
        if (lrclk != prevLr)
        begin
            if (lrEdges > 0)
                checkThat(bitCount == `SLOT_WIDTH,
                    $sformatf("lrclk held %0d bclk periods, expected %0d",
                        bitCount, `SLOT_WIDTH));
            lrEdges++;
            bitCount = 0;
            if (!prevLr)
                leftSlot = shiftWord;
            else
                checkDecodedFrame(leftSlot, shiftWord);
        end
        prevLr = lrclk;
    endtask

    // Line empties, then the given number of silent frames go by
    task automatic waitForDrain(input int silentFrames);
        int base;
        while (expected.size() != 0)
            @(negedge audioClk);
        base = zeroFrames;
        while (zeroFrames < base + silentFrames)
            @(negedge audioClk);
    endtask

    //----------------------------------------------------------------------
    // Line monitor, sampled mid-cycle
    //----------------------------------------------------------------------

    always @(negedge audioClk)
    begin
        if (reset)
        begin
            prevBclk = 1'b0;
            prevLr = 1'b0;
            underrunLast = 1'b0;
            halfCount = 0;
            bclkToggles = 0;
            bitCount = 0;
            lrEdges = 0;
            shiftWord = '0;
        end
        else
        begin
            // bclk half periods, first one skipped
            if (bclk == prevBclk)
                halfCount++;
            else
            begin
                if (bclkToggles > 0)
                    checkThat(halfCount == `BCLK_HALF,
                        $sformatf("bclk half period %0d cycles, expected %0d",
                            halfCount, `BCLK_HALF));
                bclkToggles++;
                halfCount = 1;
            end
            // Single-cycle pulse right before lrclk goes low
            if (underrunLast)
                checkThat(!underrun && !lrclk,
                    $sformatf("after underrun: underrun %b lrclk %b", underrun, lrclk));
            if (underrun)
            begin
                checkThat(bclk == 1'b1, "underrun pulse not on a bclk fall");
                pendingUnderruns++;
            end
            underrunLast = underrun;
            if (bclk && !prevBclk)
                decodeBit();
            prevBclk = bclk;
        end
    end

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------

    initial
    begin
        int row;
        int burstDone;
        void'($urandom(32'ha917db95));
        reset = 1'b1;
        sampleWrite = 1'b0;
        sampleData = '0;
        burstDone = 0;
        fillTable();
        repeat (2)
        begin
            @(negedge audioClk);
            checkResetLevels("during reset");
        end
        reset = 1'b0;
        @(negedge audioClk);
        checkResetLevels("after reset");
        for (row = 0; row < TableRows; row++)
        begin
            if (!burstTab[row])
            begin
                // Writer respects fifoFull
                while (fifoFull)
                    @(negedge audioClk);
                writeFrame(frameTab[row]);
                expected.push_back(frameTab[row]);
            end
            else
            begin
                // Table exhausted, then a burst just after a frame start
                if (row == StreamRows)
                    waitForDrain(2);
                checkThat(fifoFull == (burstDone >= `FIFO_DEPTH),
                    $sformatf("fifoFull %b after %0d burst writes", fifoFull, burstDone));
                writeFrame(frameTab[row]);
                if (acceptTab[row])
                    expected.push_back(frameTab[row]);
                burstDone++;
            end
        end
        checkThat(fifoFull == 1'b1, "fifoFull low after the burst");
        // Dropped frames would show up before this silent frame
        waitForDrain(1);
        checkThat(pendingUnderruns <= 1,
            $sformatf("%0d underrun pulses without a zero frame", pendingUnderruns));
        checkThat(fifoFull == 1'b0, "fifoFull still high after drain");
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TimeoutNs);
        $display("Timeout: run did not finish within %0d ns", TimeoutNs);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
audioSamplePkg.sv
i2sTimingPkg.sv
sampleFifo.sv
i2sClockGen.sv
i2sSerializer.sv
i2sTransmitter.sv
tb_i2sTransmitter.sv

//--- Bender.yml
package:
  name: i2s_transmitter

sources:
  - include_dirs:
      - .
    files:
      - audioSamplePkg.sv
      - i2sTimingPkg.sv
      - sampleFifo.sv
      - i2sClockGen.sv
      - i2sSerializer.sv
      - i2sTransmitter.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_i2sTransmitter.sv
